// File: verilog.f
src/iagc_pkg.sv
src/iagc_regs.sv
src/sample_decimator.sv
src/phase_detector.sv
src/amplitude_detector.sv
src/gain_processor.sv
src/iagc_top.sv
dv/iagc_assert.sv
dv/iagc_tb.sv

// File: Bender.yml
package:
  name: iagc

sources:
  - src/iagc_pkg.sv
  - src/iagc_regs.sv
  - src/sample_decimator.sv
  - src/phase_detector.sv
  - src/amplitude_detector.sv
  - src/gain_processor.sv
  - src/iagc_top.sv
  - target: simulation
    files:
      - dv/iagc_assert.sv
      - dv/iagc_tb.sv

// File: dv/iagc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module iagc_tb;
    import iagc_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 16;
    localparam int POLL_LIMIT     = 200;
    localparam int SIGNS_RANDOM   = 0;
    localparam int SIGNS_SAME     = 1;
    localparam int SIGNS_OPPOSITE = 2;

    logic      i_clock;
    logic      i_rst_n;
    logic      i_psel;
    logic      i_penable;
    logic      i_pwrite;
    apb_addr_t i_paddr;
    apb_data_t i_pwdata;
    apb_data_t o_prdata;
    logic      o_pready;
    logic      o_pslverr;
    logic      i_valid;
    sample_t   i_ref;
    sample_t   i_err;

    int          err_count;
    logic [31:0] lfsr_q = 32'd32;
    int          amp_a;
    int          amp_b;
    int          sign_mode;
    logic        valid_en;
    logic        ref_neg;
    logic        err_neg;
    apb_data_t   rdata;
    apb_data_t   exp_result;
    apb_data_t   count_before;

    iagc_top dut_i (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .i_valid   (i_valid),
        .i_ref     (i_ref),
        .i_err     (i_err)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // floor(a * 256 / b) or all ones on divide by zero and overflow
    function automatic logic [15:0] expected_gain(input int a, input int b);
        int q;
        if (b == 0)
            return 16'hFFFF;
        q = (a * 256) / b;
        return (q > 32'hFFFF) ? 16'hFFFF : 16'(q);
    endfunction

    // one sample pair per cycle with signs from the lfsr
    always begin
        @(posedge i_clock);
        #DRIVE_DELAY;
        ref_neg = lfsr_q[0];
        lfsr_q  = lfsr_next(lfsr_q);
        if (sign_mode == SIGNS_SAME) begin
            err_neg = ref_neg;
        end else if (sign_mode == SIGNS_OPPOSITE) begin
            err_neg = ~ref_neg;
        end else begin
            err_neg = lfsr_q[0];
            lfsr_q  = lfsr_next(lfsr_q);
        end
        i_valid = valid_en;
        i_ref   = ref_neg ? sample_t'(-amp_a) : sample_t'(amp_a);
        i_err   = err_neg ? sample_t'(-amp_b) : sample_t'(amp_b);
    end

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count++;
    endtask

    // setup phase then access phase then idle
    // outputs sampled mid access phase
    task automatic apb_access(input apb_addr_t addr, input logic write,
                              input apb_data_t wdata, input logic exp_err,
                              output apb_data_t data);
        @(posedge i_clock);
        #DRIVE_DELAY;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(posedge i_clock);
        #DRIVE_DELAY;
        i_penable = 1'b1;
        @(negedge i_clock);
        data = o_prdata;
        assert (o_pready === 1'b1)
            else report_error($sformatf("pready low at offset 0x%02h", addr));
        assert (o_pslverr === exp_err)
            else report_error($sformatf("pslverr %b at offset 0x%02h", o_pslverr, addr));
        @(posedge i_clock);
        #DRIVE_DELAY;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
        apb_data_t unused;
        apb_access(addr, 1'b1, data, exp_err, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, input logic exp_err, output apb_data_t data);
        apb_access(addr, 1'b0, '0, exp_err, data);
    endtask

    task automatic check_read(input apb_addr_t addr, input apb_data_t exp);
        apb_data_t data;
        apb_read(addr, 1'b0, data);
        assert (data === exp)
            else report_error($sformatf("offset 0x%02h read 0x%0h, expected 0x%0h",
                                        addr, data, exp));
    endtask

    // poll the result count until n more results arrived
    task automatic wait_results(input int n);
        apb_data_t start_cnt;
        apb_data_t cnt;
        int        polls;
        apb_read(REG_RESULT_COUNT, 1'b0, start_cnt);
        cnt   = start_cnt;
        polls = 0;
        while (cnt < start_cnt + n && polls < POLL_LIMIT) begin
            apb_read(REG_RESULT_COUNT, 1'b0, cnt);
            polls++;
        end
        if (cnt < start_cnt + n) begin
            $display("timeout: result count stuck at %0d, waiting for %0d more", cnt, n);
            $display("test failed");
            $finish;
        end
    endtask

    // restart with new magnitudes and check a result from the new windows
    task automatic check_gain(input int a, input int b, input int mode);
        apb_data_t   res;
        logic [15:0] exp;
        apb_write(REG_CTRL, 32'd0, 1'b0);
        amp_a     = a;
        amp_b     = b;
        sign_mode = mode;
        apb_write(REG_CTRL, 32'd1, 1'b0);
        // the first result after restart may still come from the old magnitudes
        wait_results(2);
        apb_read(REG_RESULT, 1'b0, res);
        exp = expected_gain(a, b);
        assert (res[15:0] == exp)
            else report_error($sformatf("gain %0d/%0d read 0x%04h, expected 0x%04h",
                                        a, b, res[15:0], exp));
        if (mode == SIGNS_SAME) begin
            assert (res[16] == 1'b1) else report_error("in-phase flag low for matching signs");
        end
        if (mode == SIGNS_OPPOSITE) begin
            assert (res[16] == 1'b0) else report_error("in-phase flag high for opposite signs");
        end
    endtask

    initial begin
        err_count = 0;
        i_rst_n   = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        i_valid   = 1'b0;
        i_ref     = '0;
        i_err     = '0;
        amp_a     = 0;
        amp_b     = 0;
        sign_mode = SIGNS_RANDOM;
        valid_en  = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clock);
        #DRIVE_DELAY;
        i_rst_n = 1'b1;

        // defaults after reset
        check_read(REG_CTRL, 32'd0);
        check_read(REG_DECIM, apb_data_t'(DEF_DECIMATOR));
        check_read(REG_PHASE_COUNT, apb_data_t'(DEF_PHASE_COUNT));
        check_read(REG_AMP_COUNT, apb_data_t'(DEF_AMPLITUDE_COUNT));
        check_read(REG_RESULT, 32'd0);
        check_read(REG_RESULT_COUNT, 32'd0);
        // unmapped read, read-only write and zero factor
        apb_read(8'h20, 1'b1, rdata);
        apb_write(REG_RESULT, 32'h1, 1'b1);
        check_read(REG_RESULT, 32'd0);
        apb_write(REG_DECIM, 32'd0, 1'b0);
        check_read(REG_DECIM, apb_data_t'(DEF_DECIMATOR));

        // ratio, phase flag and saturation at decimation 1 with windows of 8
        apb_write(REG_DECIM, 32'd1, 1'b0);
        apb_write(REG_PHASE_COUNT, 32'd8, 1'b0);
        apb_write(REG_AMP_COUNT, 32'd8, 1'b0);
        valid_en = 1'b1;
        check_gain(1000, 500, SIGNS_RANDOM);
        check_gain(300, 1000, SIGNS_RANDOM);
        check_gain(5000, 77, SIGNS_RANDOM);
        check_gain(700, 650, SIGNS_SAME);
        check_gain(700, 650, SIGNS_OPPOSITE);
        check_gain(4000, 0, SIGNS_RANDOM);
        check_gain(2560, 10, SIGNS_SAME);

        // decimation 3 with the count still rising
        apb_write(REG_CTRL, 32'd0, 1'b0);
        apb_write(REG_DECIM, 32'd3, 1'b0);
        check_read(REG_DECIM, 32'd3);
        check_gain(1200, 400, SIGNS_SAME);
        wait_results(1);
        // fixed magnitudes and matching signs, so every new result reads the same
        exp_result = apb_data_t'({1'b1, expected_gain(1200, 400)});
        check_read(REG_RESULT, exp_result);
        check_read(REG_RESULT, exp_result);

        // count frozen while stopped under a long stretch of valid samples
        apb_write(REG_CTRL, 32'd0, 1'b0);
        apb_read(REG_RESULT_COUNT, 1'b0, count_before);
        repeat (300) @(posedge i_clock);
        check_read(REG_RESULT_COUNT, count_before);

        $display("errors: %0d, assertion failures: %0d", err_count, dut_i.assert_i.fail_count);
        if (err_count == 0 && dut_i.assert_i.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/iagc_assert.sv
`timescale 1ns/1ns
`default_nettype none

module iagc_assert (
    input wire        i_clock,
    input wire        i_rst_n,
    input wire        i_psel,
    input wire        i_penable,
    input wire        i_pready,
    input wire        i_pslverr,
    input wire        i_run,
    input wire [15:0] i_result_count
);

    // number of assertion failures
    int unsigned fail_count = 0;

    // apb responses only in the access phase
    pready_in_access: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_pready |-> (i_psel && i_penable))
        else begin
            fail_count++;
            $error("pready outside an access phase");
        end

    pslverr_in_access: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_pslverr |-> (i_psel && i_penable))
        else begin
            fail_count++;
            $error("pslverr outside an access phase");
        end

    // counter only moves up
    count_rising: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_result_count < $past(i_result_count)))
        else begin
            fail_count++;
            $error("result count decreased");
        end

    // no new results registered while stopped
    count_frozen: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !$past(i_run) |-> $stable(i_result_count))
        else begin
            fail_count++;
            $error("result count changed while run was low");
        end

endmodule

bind iagc_top iagc_assert assert_i (
    .i_clock        (i_clock),
    .i_rst_n        (i_rst_n),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pready       (o_pready),
    .i_pslverr      (o_pslverr),
    .i_run          (run),
    .i_result_count (u_regs.result_count_q)
);

`default_nettype wire

// File: src/iagc_top.sv
`timescale 1ns/1ns
`default_nettype none

module iagc_top (
    input  wire                      i_clock,
    input  wire                      i_rst_n,
    input  wire                      i_psel,
    input  wire                      i_penable,
    input  wire                      i_pwrite,
    input  wire iagc_pkg::apb_addr_t i_paddr,
    input  wire iagc_pkg::apb_data_t i_pwdata,
    output iagc_pkg::apb_data_t      o_prdata,
    output logic                     o_pready,
    output logic                     o_pslverr,
    input  wire                      i_valid,
    input  wire iagc_pkg::sample_t   i_ref,
    input  wire iagc_pkg::sample_t   i_err
);
    import iagc_pkg::*;

    // 8 quotient + 8 fraction bits
    localparam int DIV_BITS = 16;

    logic         run;
    decim_t       decim;
    window_t      phase_count;
    window_t      amp_count;
    sample_pair_t pair;
    logic         pair_valid;
    logic         in_phase;
    amplitude_t   ref_amp;
    amplitude_t   err_amp;
    logic         amp_valid;
    gain_t        gain;
    logic         gain_valid;

    iagc_regs u_regs (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .i_gain        (gain),
        .i_gain_valid  (gain_valid),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .o_run         (run),
        .o_decim       (decim),
        .o_phase_count (phase_count),
        .o_amp_count   (amp_count)
    );

    sample_decimator u_decimator (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_run        (run),
        .i_decim      (decim),
        .i_valid      (i_valid),
        .i_ref        (i_ref),
        .i_err        (i_err),
        .o_pair       (pair),
        .o_pair_valid (pair_valid)
    );

    // both detectors see the same decimated stream
    phase_detector u_phase_detector (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_run         (run),
        .i_pair        (pair),
        .i_pair_valid  (pair_valid),
        .i_phase_count (phase_count),
        .o_in_phase    (in_phase)
    );

    amplitude_detector u_amplitude_detector (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_run        (run),
        .i_pair       (pair),
        .i_pair_valid (pair_valid),
        .i_amp_count  (amp_count),
        .o_ref_amp    (ref_amp),
        .o_err_amp    (err_amp),
        .o_amp_valid  (amp_valid)
    );

    gain_processor #(
        .DIV_BITS (DIV_BITS)
    ) u_gain_processor (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_ref_amp    (ref_amp),
        .i_err_amp    (err_amp),
        .i_amp_valid  (amp_valid),
        .i_in_phase   (in_phase),
        .o_gain       (gain),
        .o_gain_valid (gain_valid)
    );

endmodule

`default_nettype wire

// File: src/gain_processor.sv
`timescale 1ns/1ns
`default_nettype none

module gain_processor #(
    parameter int DIV_BITS = 16
) (
    input  wire                       i_clock,
    input  wire                       i_rst_n,
    input  wire iagc_pkg::amplitude_t i_ref_amp,
    input  wire iagc_pkg::amplitude_t i_err_amp,
    input  wire                       i_amp_valid,
    input  wire                       i_in_phase,
    output iagc_pkg::gain_t           o_gain,
    output logic                      o_gain_valid
);
    import iagc_pkg::*;

    // numerator is ref scaled by 2^FRAC_W
    localparam int NUM_W = SAMPLE_W + FRAC_W;
    localparam int CNT_W = $clog2(DIV_BITS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DIV_BITS - 1);

    typedef enum logic {
        ST_IDLE,
        ST_DIVIDE
    } div_state_t;

    div_state_t          state_q;
    logic [CNT_W-1:0]    step_q;
    logic [NUM_W-1:0]    numer;
    logic [NUM_W-1:0]    rem_init;
    amplitude_t          divisor_q;
    amplitude_t          rem_q;
    logic [DIV_BITS-1:0] quot_q;
    logic                sat_q;
    logic                in_phase_q;
    logic [SAMPLE_W:0]   rem_shift;
    logic                rem_ge;
    amplitude_t          rem_next;
    logic [DIV_BITS-1:0] quot_next;
    logic                start;
    logic                last;

    assign numer    = {i_ref_amp, {FRAC_W{1'b0}}};
    // bits above the quotient window seed the remainder
    assign rem_init = numer >> DIV_BITS;

    assign start = (state_q == ST_IDLE) & i_amp_valid;
    assign last  = (state_q == ST_DIVIDE) & (step_q == LAST_STEP);

    // restoring step, dividend bits shift out the top of quot_q
    assign rem_shift = {rem_q, quot_q[DIV_BITS-1]};
    assign rem_ge    = (rem_shift >= {1'b0, divisor_q});
    assign rem_next  = rem_ge ? amplitude_t'(rem_shift - {1'b0, divisor_q})
                              : amplitude_t'(rem_shift);
    assign quot_next = {quot_q[DIV_BITS-2:0], rem_ge};

    // strobes taken while busy are lost
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state_q      <= ST_IDLE;
            step_q       <= '0;
            o_gain_valid <= 1'b0;
        end else begin
            o_gain_valid <= last;
            case (state_q)
                ST_IDLE: begin
                    step_q <= '0;
                    if (i_amp_valid)
                        state_q <= ST_DIVIDE;
                end
                ST_DIVIDE: begin
                    step_q <= step_q + 1'b1;
                    if (last)
                        state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (start) begin
            divisor_q  <= i_err_amp;
            rem_q      <= amplitude_t'(rem_init);
            quot_q     <= numer[DIV_BITS-1:0];
            // quotient too wide, or divide by zero
            sat_q      <= (rem_init >= NUM_W'(i_err_amp));
            in_phase_q <= i_in_phase;
        end else if (state_q == ST_DIVIDE) begin
            rem_q  <= rem_next;
            quot_q <= quot_next;
        end
        if (last) begin
            o_gain.in_phase <= in_phase_q;
            o_gain.quotient <= sat_q ? '1 : quot_next[DIV_BITS-1 -: QUOT_W];
            o_gain.fraction <= sat_q ? '1 : quot_next[DIV_BITS-QUOT_W-1 -: FRAC_W];
        end
    end

endmodule

`default_nettype wire

// File: src/amplitude_detector.sv
`timescale 1ns/1ns
`default_nettype none

module amplitude_detector (
    input  wire                         i_clock,
    input  wire                         i_rst_n,
    input  wire                         i_run,
    input  wire iagc_pkg::sample_pair_t i_pair,
    input  wire                         i_pair_valid,
    input  wire iagc_pkg::window_t      i_amp_count,
    output iagc_pkg::amplitude_t        o_ref_amp,
    output iagc_pkg::amplitude_t        o_err_amp,
    output logic                        o_amp_valid
);
    import iagc_pkg::*;

    window_t    sample_cnt_q;
    amplitude_t ref_peak_q;
    amplitude_t err_peak_q;
    amplitude_t ref_mag;
    amplitude_t err_mag;
    amplitude_t ref_peak;
    amplitude_t err_peak;
    logic       window_end;

    // most negative code maps to 2^(w-1), still fits unsigned
    function automatic amplitude_t magnitude(input sample_t s);
        return s[SAMPLE_W-1] ? amplitude_t'(-s) : amplitude_t'(s);
    endfunction

    assign ref_mag = magnitude(i_pair.ref_smp);
    assign err_mag = magnitude(i_pair.err_smp);

    // first sample of a window overrides stale peak
    assign ref_peak = (sample_cnt_q == '0 || ref_mag > ref_peak_q) ? ref_mag : ref_peak_q;
    assign err_peak = (sample_cnt_q == '0 || err_mag > err_peak_q) ? err_mag : err_peak_q;

    assign window_end = (sample_cnt_q >= window_t'(i_amp_count - 1'b1));

    always_ff @(posedge i_clock) begin
        if (!i_rst_n || !i_run) begin
            sample_cnt_q <= '0;
            o_amp_valid  <= 1'b0;
        end else begin
            o_amp_valid <= i_pair_valid & window_end;
            if (i_pair_valid)
                sample_cnt_q <= window_end ? '0 : sample_cnt_q + 1'b1;
        end
    end

    // running peaks and window result
    always_ff @(posedge i_clock) begin
        if (i_pair_valid) begin
            ref_peak_q <= ref_peak;
            err_peak_q <= err_peak;
            if (window_end) begin
                o_ref_amp <= ref_peak;
                o_err_amp <= err_peak;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/phase_detector.sv
`timescale 1ns/1ns
`default_nettype none

module phase_detector (
    input  wire                         i_clock,
    input  wire                         i_rst_n,
    input  wire                         i_run,
    input  wire iagc_pkg::sample_pair_t i_pair,
    input  wire                         i_pair_valid,
    input  wire iagc_pkg::window_t      i_phase_count,
    output logic                        o_in_phase
);
    import iagc_pkg::*;

    window_t sample_cnt_q;
    window_t agree_cnt_q;
    window_t agree_total;
    logic    agree;
    logic    window_end;

    // same sign bit on both channels, zero counts as positive
    assign agree = (i_pair.ref_smp[SAMPLE_W-1] == i_pair.err_smp[SAMPLE_W-1]);

    // agreements including the current sample
    assign agree_total = agree_cnt_q + window_t'(agree);
    assign window_end  = (sample_cnt_q >= window_t'(i_phase_count - 1'b1));

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            sample_cnt_q <= '0;
            agree_cnt_q  <= '0;
            o_in_phase   <= 1'b0;
        end else if (!i_run) begin
            // fresh window on next run, flag held
            sample_cnt_q <= '0;
            agree_cnt_q  <= '0;
        end else if (i_pair_valid) begin
            if (window_end) begin
                sample_cnt_q <= '0;
                agree_cnt_q  <= '0;
                // strict majority of the window
                o_in_phase   <= (agree_total > (i_phase_count >> 1));
            end else begin
                sample_cnt_q <= sample_cnt_q + 1'b1;
                agree_cnt_q  <= agree_total;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/sample_decimator.sv
`timescale 1ns/1ns
`default_nettype none

module sample_decimator (
    input  wire                    i_clock,
    input  wire                    i_rst_n,
    input  wire                    i_run,
    input  wire iagc_pkg::decim_t  i_decim,
    input  wire                    i_valid,
    input  wire iagc_pkg::sample_t i_ref,
    input  wire iagc_pkg::sample_t i_err,
    output iagc_pkg::sample_pair_t o_pair,
    output logic                   o_pair_valid
);
    import iagc_pkg::*;

    decim_t cnt_q;
    logic   take;

    // nth accepted valid cycle, >= covers a factor lowered mid count
    assign take = i_run & i_valid & (cnt_q >= decim_t'(i_decim - 1'b1));

    // counter restarts whenever run drops
    always_ff @(posedge i_clock) begin
        if (!i_rst_n || !i_run) begin
            cnt_q        <= '0;
            o_pair_valid <= 1'b0;
        end else begin
            o_pair_valid <= take;
            if (i_valid)
                cnt_q <= take ? '0 : cnt_q + 1'b1;
        end
    end

    // capture kept pair
    always_ff @(posedge i_clock) begin
        if (take) begin
            o_pair.ref_smp <= i_ref;
            o_pair.err_smp <= i_err;
        end
    end

endmodule

`default_nettype wire

// File: src/iagc_regs.sv
`timescale 1ns/1ns
`default_nettype none

module iagc_regs (
    input  wire                      i_clock,
    input  wire                      i_rst_n,
    input  wire                      i_psel,
    input  wire                      i_penable,
    input  wire                      i_pwrite,
    input  wire iagc_pkg::apb_addr_t i_paddr,
    input  wire iagc_pkg::apb_data_t i_pwdata,
    input  wire iagc_pkg::gain_t     i_gain,
    input  wire                      i_gain_valid,
    output iagc_pkg::apb_data_t      o_prdata,
    output logic                     o_pready,
    output logic                     o_pslverr,
    output logic                     o_run,
    output iagc_pkg::decim_t         o_decim,
    output iagc_pkg::window_t        o_phase_count,
    output iagc_pkg::window_t        o_amp_count
);
    import iagc_pkg::*;

    logic        access;
    logic        addr_hit;
    logic        addr_ro;
    logic        wr_en;
    gain_t       result_q;
    logic [15:0] result_count_q;

    // apb access phase, zero wait states
    assign access   = i_psel & i_penable;
    assign o_pready = access;

    // address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        o_prdata = '0;
        case (i_paddr)
            REG_CTRL:        o_prdata = apb_data_t'(o_run);
            REG_DECIM:       o_prdata = apb_data_t'(o_decim);
            REG_PHASE_COUNT: o_prdata = apb_data_t'(o_phase_count);
            REG_AMP_COUNT:   o_prdata = apb_data_t'(o_amp_count);
            REG_RESULT: begin
                o_prdata = apb_data_t'(result_q);
                addr_ro  = 1'b1;
            end
            REG_RESULT_COUNT: begin
                o_prdata = apb_data_t'(result_count_q);
                addr_ro  = 1'b1;
            end
            default:         addr_hit = 1'b0;
        endcase
    end

    // error on unmapped offset or write to result registers
    assign o_pslverr = access & (~addr_hit | (i_pwrite & addr_ro));
    assign wr_en     = access & i_pwrite & addr_hit & ~addr_ro;

    // configuration writes, zero lengths and factors rejected
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_run         <= 1'b0;
            o_decim       <= DEF_DECIMATOR;
            o_phase_count <= DEF_PHASE_COUNT;
            o_amp_count   <= DEF_AMPLITUDE_COUNT;
        end else if (wr_en) begin
            case (i_paddr)
                REG_CTRL: o_run <= i_pwdata[0];
                REG_DECIM: begin
                    if (decim_t'(i_pwdata) != '0)
                        o_decim <= decim_t'(i_pwdata);
                end
                REG_PHASE_COUNT: begin
                    if (window_t'(i_pwdata) != '0)
                        o_phase_count <= window_t'(i_pwdata);
                end
                REG_AMP_COUNT: begin
                    if (window_t'(i_pwdata) != '0)
                        o_amp_count <= window_t'(i_pwdata);
                end
                default: ;
            endcase
        end
    end

    // latest result and result counter, frozen while stopped
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            result_q       <= '0;
            result_count_q <= '0;
        end else if (i_gain_valid && o_run) begin
            result_q       <= i_gain;
            result_count_q <= result_count_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/iagc_pkg.sv
`default_nettype none

package iagc_pkg;

    // converter sample width
    localparam int SAMPLE_W = 14;
    // gain integer and fraction widths
    localparam int QUOT_W = 8;
    localparam int FRAC_W = 8;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [SAMPLE_W-1:0] amplitude_t;
    typedef logic [15:0] window_t;
    typedef logic [3:0] decim_t;
    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // one decimated reference/error pair
    typedef struct packed {
        sample_t ref_smp;
        sample_t err_smp;
    } sample_pair_t;

    // in_phase sits above quotient and fraction in readback
    typedef struct packed {
        logic              in_phase;
        logic [QUOT_W-1:0] quotient;
        logic [FRAC_W-1:0] fraction;
    } gain_t;

    // register map
    localparam apb_addr_t REG_CTRL         = 8'h00;
    localparam apb_addr_t REG_DECIM        = 8'h04;
    localparam apb_addr_t REG_PHASE_COUNT  = 8'h08;
    localparam apb_addr_t REG_AMP_COUNT    = 8'h0C;
    localparam apb_addr_t REG_RESULT       = 8'h10;
    localparam apb_addr_t REG_RESULT_COUNT = 8'h14;

    // configuration after reset
    localparam decim_t  DEF_DECIMATOR       = 4'd4;
    localparam window_t DEF_PHASE_COUNT     = 16'd256;
    localparam window_t DEF_AMPLITUDE_COUNT = 16'd256;

endpackage

`default_nettype wire
